//--- Bender.yml
package:
  name: wan_seq_repo

sources:
  - rpn_msg_pkg.sv
  - wan_seq_pkg.sv
  - seq_table.sv
  - node_seq_check.sv
  - wan_owner_lock.sv
  - rpn_seq_ctrl.sv
  - wan_seq_repo.sv
  - target: simulation
    files:
      - tb_wan_seq_repo.sv

//--- files.f
rpn_msg_pkg.sv
wan_seq_pkg.sv
seq_table.sv
node_seq_check.sv
wan_owner_lock.sv
rpn_seq_ctrl.sv
wan_seq_repo.sv
tb_wan_seq_repo.sv

//--- node_seq_check.sv
`timescale 1ns/1ps

module node_seq_check import wan_seq_pkg::*; #(
    parameter int SEQ_W = 16
) (
    input  logic [SEQ_W-1:0] i_stored_seq,
    input  logic [SEQ_W-1:0] i_sender_seq,
    output seq_verdict_t     o_verdict
);

    logic [SEQ_W-1:0] w_expected_seq;
    logic             w_is_next;
    logic             w_is_same;

    // The all-ones value rolls over to zero through truncation
    assign w_expected_seq = i_stored_seq + SEQ_W'(1);

    assign w_is_next = (i_sender_seq == w_expected_seq);
    assign w_is_same = (i_sender_seq == i_stored_seq);

    // A repeat is a retransmission of the most recent request from this node
    always_comb begin
        if (w_is_next) begin
            o_verdict = VERDICT_NEW;
        end else if (w_is_same) begin
            o_verdict = VERDICT_REPEAT;
        end else begin
            o_verdict = VERDICT_REJECT;
        end
    end

endmodule

//--- rpn_msg_pkg.sv
package rpn_msg_pkg;

    // Codes carried in the message type field of requests and replies
    typedef enum logic [3:0] {
        MSG_NODE_SEQ_CHECK = 4'd1,
        MSG_NODE_SEQ_REPLY = 4'd2,
        MSG_WAN_READ       = 4'd3,
        MSG_WAN_READ_REPLY = 4'd4,
        MSG_WAN_WRITE      = 4'd5,
        MSG_WAN_WRITE_RESP = 4'd6,
        MSG_WAN_CHECK      = 4'd7,
        MSG_WAN_CHECK_DATA = 4'd8
    } msg_type_t;

    // Maps a request code to the code of its reply
    // Codes that are not requests come back unchanged
    function automatic msg_type_t reply_code(input msg_type_t req);
        msg_type_t rep;
        case (req)
            MSG_NODE_SEQ_CHECK: rep = MSG_NODE_SEQ_REPLY;
            MSG_WAN_READ:       rep = MSG_WAN_READ_REPLY;
            MSG_WAN_WRITE:      rep = MSG_WAN_WRITE_RESP;
            MSG_WAN_CHECK:      rep = MSG_WAN_CHECK_DATA;
            default:            rep = req;
        endcase
        return rep;
    endfunction

endpackage

//--- rpn_seq_ctrl.sv
`timescale 1ns/1ps

module rpn_seq_ctrl import rpn_msg_pkg::*, wan_seq_pkg::*; #(
    parameter int NODE_ID_W  = 8,
    parameter int SEQ_W      = 16,
    parameter int WAN_SEQ_W  = 32,
    parameter int WAN_DEST_W = 6
) (
    input  logic                  i_clk,
    input  logic                  i_ap_rst_n,
    // Request side
    input  logic                  i_req_valid,
    output logic                  o_req_ready,
    input  msg_type_t             i_req_msg_type,
    input  logic [NODE_ID_W-1:0]  i_req_sender_id,
    input  logic [SEQ_W-1:0]      i_req_seq_num,
    input  logic [WAN_DEST_W-1:0] i_req_wan_dest,
    // Reply side
    output logic                  o_rep_valid,
    input  logic                  i_rep_ready,
    output msg_type_t             o_rep_msg_type,
    output logic [SEQ_W-1:0]      o_rep_seq_num,
    output logic [WAN_SEQ_W-1:0]  o_rep_wan_seq_num,
    output logic [WAN_DEST_W-1:0] o_rep_wan_dest,
    output logic                  o_rep_locked,
    // Decision logic and tables
    input  logic [SEQ_W-1:0]      i_node_seq_rd,
    input  seq_verdict_t          i_verdict,
    input  logic [WAN_SEQ_W-1:0]  i_report_seq,
    input  logic                  i_report_locked,
    output logic                  o_node_rd_en,
    output logic                  o_node_wr_en,
    output logic [NODE_ID_W-1:0]  o_node_addr,
    output logic [SEQ_W-1:0]      o_node_wr_data,
    output logic                  o_wan_rd_en,
    output logic [WAN_DEST_W-1:0] o_wan_addr,
    output logic                  o_access,
    output msg_type_t             o_msg_type,
    output logic [NODE_ID_W-1:0]  o_sender_id
);

    core_state_t r_state;
    core_state_t w_next_state;
    logic        w_req_accept;

    // Captured request
    msg_type_t             r_msg_type;
    logic [NODE_ID_W-1:0]  r_sender_id;
    logic [SEQ_W-1:0]      r_seq_num;
    logic [WAN_DEST_W-1:0] r_wan_dest;

    assign o_req_ready  = (r_state == ST_IDLE);
    assign o_rep_valid  = (r_state == ST_TRANSMIT);
    assign w_req_accept = i_req_valid && o_req_ready;

    always_comb begin
        w_next_state = r_state;
        case (r_state)
            ST_IDLE: begin
                if (i_req_valid) begin
                    w_next_state = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                case (r_msg_type)
                    MSG_NODE_SEQ_CHECK: w_next_state = ST_TRANSMIT;
                    MSG_WAN_READ, MSG_WAN_CHECK: begin
                        // A retransmitted read goes back to the tables and locks again
                        case (i_verdict)
                            VERDICT_NEW:    w_next_state = ST_WRITE_NODE;
                            VERDICT_REPEAT: w_next_state = ST_ACCESS;
                            default:        w_next_state = ST_IDLE;
                        endcase
                    end
                    MSG_WAN_WRITE: begin
                        // A retransmitted write was already applied so it is only acknowledged
                        case (i_verdict)
                            VERDICT_NEW:    w_next_state = ST_WRITE_NODE;
                            VERDICT_REPEAT: w_next_state = ST_TRANSMIT;
                            default:        w_next_state = ST_IDLE;
                        endcase
                    end
                    default: w_next_state = ST_IDLE;
                endcase
            end
            ST_WRITE_NODE: w_next_state = ST_ACCESS;
            ST_ACCESS:     w_next_state = ST_TRANSMIT;
            ST_TRANSMIT: begin
                if (i_rep_ready) begin
                    w_next_state = ST_IDLE;
                end
            end
            default: w_next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            r_state <= ST_IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_req_accept) begin
            r_msg_type  <= i_req_msg_type;
            r_sender_id <= i_req_sender_id;
            r_seq_num   <= i_req_seq_num;
            r_wan_dest  <= i_req_wan_dest;
        end
    end

    // Node table is read while the request is still on the input
    assign o_node_rd_en   = w_req_accept;
    assign o_node_addr    = (r_state == ST_IDLE) ? i_req_sender_id : r_sender_id;
    assign o_node_wr_en   = (r_state == ST_WRITE_NODE);
    assign o_node_wr_data = r_seq_num;

    // WAN and owner tables are read one cycle ahead of access
    assign o_wan_rd_en = (w_next_state == ST_ACCESS);
    assign o_wan_addr  = r_wan_dest;
    assign o_access    = (r_state == ST_ACCESS);
    assign o_msg_type  = r_msg_type;
    assign o_sender_id = r_sender_id;

    always_ff @(posedge i_clk) begin
        if (w_req_accept) begin
            o_rep_wan_seq_num <= '0;
            o_rep_wan_dest    <= '0;
            o_rep_locked      <= 1'b0;
        end else if (r_state == ST_COMPARE) begin
            o_rep_msg_type <= reply_code(r_msg_type);
            if (r_msg_type == MSG_NODE_SEQ_CHECK) begin
                o_rep_seq_num <= i_node_seq_rd;
            end else begin
                o_rep_seq_num <= r_seq_num;
            end
        end else if (o_access) begin
            o_rep_wan_seq_num <= i_report_seq;
            o_rep_wan_dest    <= r_wan_dest;
            o_rep_locked      <= i_report_locked;
        end
    end

    a_one_item_in_flight: assert property (
        @(posedge i_clk) disable iff (!i_ap_rst_n)
        !(o_rep_valid && o_req_ready)
    ) else $error("rpn_seq_ctrl: request and reply open at the same time");

    // A stalled reply keeps every field until the receiver takes it
    a_reply_stable: assert property (
        @(posedge i_clk) disable iff (!i_ap_rst_n)
        o_rep_valid && !i_rep_ready |=> o_rep_valid
            && $stable(o_rep_msg_type) && $stable(o_rep_seq_num)
            && $stable(o_rep_wan_seq_num) && $stable(o_rep_wan_dest)
            && $stable(o_rep_locked)
    ) else $error("rpn_seq_ctrl: reply changed under back-pressure");

endmodule

//--- seq_table.sv
`timescale 1ns/1ps

module seq_table #(
    parameter type entry_t = logic [7:0],
    parameter int  ADDR_W  = 4
) (
    input  logic              i_clk,
    input  logic              i_ap_rst_n,
    input  logic              i_rd_en,
    input  logic              i_wr_en,
    input  logic [ADDR_W-1:0] i_addr,
    input  entry_t            i_wr_data,
    output entry_t            o_rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    entry_t r_mem [DEPTH];

    // Every entry starts at zero, so owner 0 reads as unowned after reset
    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            r_mem <= '{default: '0};
        end else if (i_wr_en) begin
            r_mem[i_addr] <= i_wr_data;
        end
    end

    // Read data holds its value until the next read enable
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= r_mem[i_addr];
        end
    end

    // The controller never reads and writes a table in the same cycle
    a_no_rd_wr_overlap: assert property (
        @(posedge i_clk) disable iff (!i_ap_rst_n)
        !(i_rd_en && i_wr_en)
    ) else $error("seq_table: read and write enabled in the same cycle");

endmodule

//--- tb_wan_seq_repo.sv
`timescale 1ns/1ps

module tb_wan_seq_repo import rpn_msg_pkg::*;;

    localparam int NODE_ID_W  = 8;
    // Narrow node numbers so the wrap from the maximum back to zero is reachable
    localparam int SEQ_W      = 4;
    localparam int WAN_SEQ_W  = 32;
    localparam int WAN_DEST_W = 6;
    localparam int REPLY_WAIT = 20;
    // About 40 requests at under 10 cycles each, with a wide margin
    localparam int TIMEOUT_CYCLES = 40 * 10 * 5;

    logic                  i_clk;
    logic                  i_ap_rst_n;
    logic                  i_req_valid;
    logic                  o_req_ready;
    msg_type_t             i_req_msg_type;
    logic [NODE_ID_W-1:0]  i_req_sender_id;
    logic [SEQ_W-1:0]      i_req_seq_num;
    logic [WAN_DEST_W-1:0] i_req_wan_dest;
    logic                  o_rep_valid;
    logic                  i_rep_ready;
    msg_type_t             o_rep_msg_type;
    logic [SEQ_W-1:0]      o_rep_seq_num;
    logic [WAN_SEQ_W-1:0]  o_rep_wan_seq_num;
    logic [WAN_DEST_W-1:0] o_rep_wan_dest;
    logic                  o_rep_locked;

    // Reference copies of the node, owner and WAN tables
    logic [SEQ_W-1:0]      m_node  [2**NODE_ID_W];
    logic [NODE_ID_W-1:0]  m_owner [2**WAN_DEST_W];
    logic [WAN_SEQ_W-1:0]  m_wan   [2**WAN_DEST_W];

    logic [15:0]           lfsr_state;
    logic [WAN_DEST_W-1:0] d_a;
    logic [WAN_DEST_W-1:0] d_b;
    logic [WAN_DEST_W-1:0] d_c;
    logic [WAN_DEST_W-1:0] d_d;
    logic [WAN_DEST_W-1:0] d_e;
    int                    checks = 0;
    int                    value_errors = 0;
    int                    protocol_errors = 0;
    int                    cycle_count = 0;

    wan_seq_repo #(
        .NODE_ID_W  (NODE_ID_W),
        .SEQ_W      (SEQ_W),
        .WAN_SEQ_W  (WAN_SEQ_W),
        .WAN_DEST_W (WAN_DEST_W)
    ) DUT (
        .i_clk             (i_clk),
        .i_ap_rst_n        (i_ap_rst_n),
        .i_req_valid       (i_req_valid),
        .o_req_ready       (o_req_ready),
        .i_req_msg_type    (i_req_msg_type),
        .i_req_sender_id   (i_req_sender_id),
        .i_req_seq_num     (i_req_seq_num),
        .i_req_wan_dest    (i_req_wan_dest),
        .o_rep_valid       (o_rep_valid),
        .i_rep_ready       (i_rep_ready),
        .o_rep_msg_type    (o_rep_msg_type),
        .o_rep_seq_num     (o_rep_seq_num),
        .o_rep_wan_seq_num (o_rep_wan_seq_num),
        .o_rep_wan_dest    (o_rep_wan_dest),
        .o_rep_locked      (o_rep_locked)
    );

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped by the cycle limit of %0d cycles", TIMEOUT_CYCLES);
            $display("checks %0d, value errors %0d, protocol errors %0d",
                     checks, value_errors, protocol_errors + 1);
            $display("tests failed");
            $finish;
        end
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    function automatic logic [SEQ_W-1:0] next_seq(input logic [NODE_ID_W-1:0] sender);
        return m_node[sender] + SEQ_W'(1);
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            value_errors++;
            $display("Fail %s: %s expected %0h actual %0h", name, field, exp, act);
        end
    endtask

    task automatic check_protocol(input string name, input logic ok, input string what);
        checks++;
        assert (ok) else begin
            protocol_errors++;
            $display("%s: %s", name, what);
        end
    endtask

    task automatic check_reply(input string name, input msg_type_t exp_type,
                               input logic [SEQ_W-1:0] exp_seq,
                               input logic [WAN_SEQ_W-1:0] exp_wan,
                               input logic [WAN_DEST_W-1:0] exp_dest,
                               input logic exp_locked);
        check_value(name, "msg_type", exp_type, o_rep_msg_type);
        check_value(name, "seq_num", exp_seq, o_rep_seq_num);
        check_value(name, "wan_seq_num", exp_wan, o_rep_wan_seq_num);
        check_value(name, "wan_dest", exp_dest, o_rep_wan_dest);
        check_value(name, "locked", exp_locked, o_rep_locked);
    endtask

    // Predicts the reply from the model, sends the request and checks what comes back
    task automatic send_request(input string name, input msg_type_t code,
                                input logic [NODE_ID_W-1:0] sender,
                                input logic [SEQ_W-1:0] seq,
                                input logic [WAN_DEST_W-1:0] dest, input int hold);
        logic                  exp_reply;
        logic                  is_wan_op;
        logic                  do_access;
        logic [SEQ_W-1:0]      exp_seq;
        logic [WAN_SEQ_W-1:0]  exp_wan;
        logic [WAN_DEST_W-1:0] exp_dest;
        logic                  exp_locked;
        msg_type_t             exp_type;
        int                    waited;

        exp_reply  = 1'b1;
        exp_seq    = seq;
        exp_wan    = '0;
        exp_dest   = '0;
        exp_locked = 1'b0;
        do_access  = 1'b0;
        // Each reply code is its request code plus one
        exp_type   = msg_type_t'(code + 4'd1);
        is_wan_op  = (code == MSG_WAN_READ) || (code == MSG_WAN_WRITE) || (code == MSG_WAN_CHECK);
        if (code == MSG_NODE_SEQ_CHECK) begin
            exp_seq = m_node[sender];
        end else if (!is_wan_op) begin
            exp_reply = 1'b0;
        end else if (seq == next_seq(sender)) begin
            m_node[sender] = seq;
            do_access = 1'b1;
        end else if (seq == m_node[sender]) begin
            // A retransmitted write was applied before and is only acknowledged
            do_access = (code != MSG_WAN_WRITE);
        end else begin
            exp_reply = 1'b0;
        end
        if (do_access) begin
            exp_dest   = dest;
            exp_locked = 1'b1;
            if (code == MSG_WAN_READ && (m_owner[dest] == '0 || m_owner[dest] == sender)) begin
                m_owner[dest] = sender;
                exp_wan       = m_wan[dest];
                exp_locked    = 1'b0;
            end else if (code == MSG_WAN_WRITE && m_owner[dest] == sender) begin
                m_owner[dest] = '0;
                exp_wan       = m_wan[dest];
                exp_locked    = 1'b0;
                m_wan[dest]   = m_wan[dest] + WAN_SEQ_W'(1);
            end else if (code == MSG_WAN_CHECK && m_owner[dest] == sender) begin
                exp_wan    = m_wan[dest];
                exp_locked = 1'b0;
            end
        end

        while (!o_req_ready) begin
            @(negedge i_clk);
        end
        i_req_valid     = 1'b1;
        i_req_msg_type  = code;
        i_req_sender_id = sender;
        i_req_seq_num   = seq;
        i_req_wan_dest  = dest;
        i_rep_ready     = (hold == 0);
        @(negedge i_clk);
        i_req_valid = 1'b0;
        waited = 0;
        while (!o_rep_valid && !o_req_ready && waited < REPLY_WAIT) begin
            @(negedge i_clk);
            waited++;
        end
        if (exp_reply) begin
            check_protocol(name, o_rep_valid, "no reply arrived after the request was accepted");
            if (o_rep_valid) begin
                check_reply(name, exp_type, exp_seq, exp_wan, exp_dest, exp_locked);
                for (int i = 0; i < hold; i++) begin
                    @(negedge i_clk);
                    check_protocol(name, o_rep_valid && !o_req_ready,
                                   "reply dropped or request side reopened under back-pressure");
                    check_reply(name, exp_type, exp_seq, exp_wan, exp_dest, exp_locked);
                end
                i_rep_ready = 1'b1;
                @(negedge i_clk);
            end
            check_protocol(name, o_req_ready, "request side did not reopen after the reply");
        end else begin
            check_protocol(name, !o_rep_valid, "a reply arrived for a request that should drop");
            check_protocol(name, o_req_ready, "request side did not reopen after a dropped request");
        end
        i_rep_ready = 1'b1;
    endtask

    task automatic test_node_check();
        send_request("node_check", MSG_WAN_CHECK, 8'd3, 4'd1, d_e, 0);
        send_request("node_check", MSG_NODE_SEQ_CHECK, 8'd3, 4'd0, d_e, 0);
        // Number 5 is neither the next nor the last one from sender 3
        send_request("node_check", MSG_WAN_READ, 8'd3, 4'd5, d_e, 0);
        send_request("node_check", msg_type_t'(4'd12), 8'd3, 4'd2, d_e, 0);
        send_request("node_check", MSG_NODE_SEQ_CHECK, 8'd3, 4'd0, d_e, 0);
    endtask

    task automatic test_read_lock();
        send_request("read_lock", MSG_WAN_READ, 8'd2, next_seq(8'd2), d_a, 0);
        send_request("read_lock", MSG_WAN_READ, 8'd4, next_seq(8'd4), d_a, 0);
        send_request("read_lock", MSG_WAN_READ, 8'd2, m_node[8'd2], d_a, 0);
    endtask

    task automatic test_write_unlock();
        send_request("write_unlock", MSG_WAN_WRITE, 8'd2, next_seq(8'd2), d_a, 0);
        send_request("write_unlock", MSG_WAN_WRITE, 8'd2, m_node[8'd2], d_a, 0);
        send_request("write_unlock", MSG_WAN_READ, 8'd4, next_seq(8'd4), d_a, 0);
        // Sender 2 no longer owns the destination
        send_request("write_unlock", MSG_WAN_WRITE, 8'd2, next_seq(8'd2), d_a, 0);
        send_request("write_unlock", MSG_WAN_WRITE, 8'd4, next_seq(8'd4), d_a, 0);
    endtask

    task automatic test_wan_check();
        send_request("wan_check", MSG_WAN_READ, 8'd5, next_seq(8'd5), d_b, 0);
        // Moves the number of this destination off zero before it is checked
        send_request("wan_check", MSG_WAN_WRITE, 8'd5, next_seq(8'd5), d_b, 0);
        send_request("wan_check", MSG_WAN_READ, 8'd5, next_seq(8'd5), d_b, 0);
        send_request("wan_check", MSG_WAN_CHECK, 8'd5, next_seq(8'd5), d_b, 0);
        send_request("wan_check", MSG_WAN_CHECK, 8'd6, next_seq(8'd6), d_b, 0);
        send_request("wan_check", MSG_WAN_CHECK, 8'd6, next_seq(8'd6), d_c, 0);
    endtask

    task automatic test_backpressure_wrap();
        int                   hold;
        logic [NODE_ID_W-1:0] s_w;
        hold = 3 + int'(rand_bits(2));
        s_w  = NODE_ID_W'(32 + rand_bits(4));
        send_request("back_pressure", MSG_WAN_READ, 8'd7, next_seq(8'd7), d_d, hold);
        // Steps the node number through its maximum and on to zero
        for (int i = 0; i < 2**SEQ_W; i++) begin
            send_request("seq_wrap", MSG_WAN_CHECK, s_w, next_seq(s_w), d_c, 0);
        end
        send_request("seq_wrap", MSG_NODE_SEQ_CHECK, s_w, 4'd0, d_c, 0);
    endtask

    initial begin
        lfsr_state      = 16'd31787;
        i_ap_rst_n      = 1'b0;
        i_req_valid     = 1'b0;
        i_req_msg_type  = MSG_NODE_SEQ_CHECK;
        i_req_sender_id = '0;
        i_req_seq_num   = '0;
        i_req_wan_dest  = '0;
        i_rep_ready     = 1'b1;
        foreach (m_node[i]) m_node[i] = '0;
        foreach (m_owner[i]) m_owner[i] = '0;
        foreach (m_wan[i]) m_wan[i] = '0;
        // Offsets keep the five destinations apart
        d_a = WAN_DEST_W'(rand_bits(6));
        d_b = d_a + WAN_DEST_W'(1 + rand_bits(4));
        d_c = d_a + WAN_DEST_W'(20 + rand_bits(4));
        d_d = d_a + WAN_DEST_W'(40 + rand_bits(4));
        d_e = d_a + WAN_DEST_W'(60);
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_ap_rst_n = 1'b1;

        test_node_check();
        test_read_lock();
        test_write_unlock();
        test_wan_check();
        test_backpressure_wrap();

        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- wan_owner_lock.sv
`timescale 1ns/1ps

module wan_owner_lock import rpn_msg_pkg::*; #(
    parameter int NODE_ID_W = 8,
    parameter int WAN_SEQ_W = 32
) (
    input  logic                 i_access,
    input  msg_type_t            i_msg_type,
    input  logic [NODE_ID_W-1:0] i_sender_id,
    input  logic [NODE_ID_W-1:0] i_owner_id,
    input  logic [WAN_SEQ_W-1:0] i_wan_seq,
    output logic                 o_owner_wr_en,
    output logic [NODE_ID_W-1:0] o_owner_wr_data,
    output logic                 o_wan_wr_en,
    output logic [WAN_SEQ_W-1:0] o_wan_wr_data,
    output logic [WAN_SEQ_W-1:0] o_report_seq,
    output logic                 o_report_locked
);

    logic w_is_owner;
    logic w_is_free;

    assign w_is_owner = (i_owner_id == i_sender_id);
    assign w_is_free  = (i_owner_id == '0);

    // Only committed when the owner writes back
    assign o_wan_wr_data = i_wan_seq + WAN_SEQ_W'(1);

    always_comb begin
        o_owner_wr_en   = 1'b0;
        o_owner_wr_data = '0;
        o_wan_wr_en     = 1'b0;
        o_report_seq    = '0;
        o_report_locked = 1'b1;
        if (i_access) begin
            case (i_msg_type)
                MSG_WAN_READ: begin
                    // Free or already ours, so take the lock and hand out the number
                    if (w_is_free || w_is_owner) begin
                        o_owner_wr_en   = 1'b1;
                        o_owner_wr_data = i_sender_id;
                        o_report_seq    = i_wan_seq;
                        o_report_locked = 1'b0;
                    end
                end
                MSG_WAN_WRITE: begin
                    // Owner releases the lock, the number moves on by one
                    if (w_is_owner) begin
                        o_owner_wr_en   = 1'b1;
                        o_owner_wr_data = '0;
                        o_wan_wr_en     = 1'b1;
                        o_report_seq    = i_wan_seq;
                        o_report_locked = 1'b0;
                    end
                end
                MSG_WAN_CHECK: begin
                    if (w_is_owner) begin
                        o_report_seq    = i_wan_seq;
                        o_report_locked = 1'b0;
                    end
                end
                default: begin
                    o_report_locked = 1'b1;
                end
            endcase
        end
    end

    // Tables may only change while the controller is in its access state
    a_wr_only_in_access: assert final (i_access || !(o_owner_wr_en || o_wan_wr_en))
        else $error("wan_owner_lock: table write outside of access");

endmodule

//--- wan_seq_pkg.sv
package wan_seq_pkg;

    // Outcome of comparing a sender sequence number with the stored one
    typedef enum logic [1:0] {
        VERDICT_NEW    = 2'd0,
        VERDICT_REPEAT = 2'd1,
        VERDICT_REJECT = 2'd2
    } seq_verdict_t;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_COMPARE    = 3'd1,
        ST_WRITE_NODE = 3'd2,
        ST_ACCESS     = 3'd3,
        ST_TRANSMIT   = 3'd4
    } core_state_t;

endpackage

//--- wan_seq_repo.sv
`timescale 1ns/1ps

module wan_seq_repo import rpn_msg_pkg::*, wan_seq_pkg::*; #(
    parameter int NODE_ID_W  = 8,
    parameter int SEQ_W      = 16,
    parameter int WAN_SEQ_W  = 32,
    parameter int WAN_DEST_W = 6
) (
    input  logic                  i_clk,
    input  logic                  i_ap_rst_n,
    input  logic                  i_req_valid,
    output logic                  o_req_ready,
    input  msg_type_t             i_req_msg_type,
    input  logic [NODE_ID_W-1:0]  i_req_sender_id,
    input  logic [SEQ_W-1:0]      i_req_seq_num,
    input  logic [WAN_DEST_W-1:0] i_req_wan_dest,
    output logic                  o_rep_valid,
    input  logic                  i_rep_ready,
    output msg_type_t             o_rep_msg_type,
    output logic [SEQ_W-1:0]      o_rep_seq_num,
    output logic [WAN_SEQ_W-1:0]  o_rep_wan_seq_num,
    output logic [WAN_DEST_W-1:0] o_rep_wan_dest,
    output logic                  o_rep_locked
);

    // Node table
    logic                  node_rd_en;
    logic                  node_wr_en;
    logic [NODE_ID_W-1:0]  node_addr;
    logic [SEQ_W-1:0]      node_wr_data;
    logic [SEQ_W-1:0]      node_rd_data;
    seq_verdict_t          verdict;

    // WAN and owner tables share address and read enable
    logic                  wan_rd_en;
    logic [WAN_DEST_W-1:0] wan_addr;
    logic                  owner_wr_en;
    logic [NODE_ID_W-1:0]  owner_wr_data;
    logic [NODE_ID_W-1:0]  owner_rd_data;
    logic                  wan_wr_en;
    logic [WAN_SEQ_W-1:0]  wan_wr_data;
    logic [WAN_SEQ_W-1:0]  wan_rd_data;

    logic                  access;
    msg_type_t             msg_type;
    logic [NODE_ID_W-1:0]  sender_id;
    logic [WAN_SEQ_W-1:0]  report_seq;
    logic                  report_locked;

    rpn_seq_ctrl #(
        .NODE_ID_W  (NODE_ID_W),
        .SEQ_W      (SEQ_W),
        .WAN_SEQ_W  (WAN_SEQ_W),
        .WAN_DEST_W (WAN_DEST_W)
    ) u_ctrl (
        .i_clk             (i_clk),
        .i_ap_rst_n        (i_ap_rst_n),
        .i_req_valid       (i_req_valid),
        .o_req_ready       (o_req_ready),
        .i_req_msg_type    (i_req_msg_type),
        .i_req_sender_id   (i_req_sender_id),
        .i_req_seq_num     (i_req_seq_num),
        .i_req_wan_dest    (i_req_wan_dest),
        .o_rep_valid       (o_rep_valid),
        .i_rep_ready       (i_rep_ready),
        .o_rep_msg_type    (o_rep_msg_type),
        .o_rep_seq_num     (o_rep_seq_num),
        .o_rep_wan_seq_num (o_rep_wan_seq_num),
        .o_rep_wan_dest    (o_rep_wan_dest),
        .o_rep_locked      (o_rep_locked),
        .i_node_seq_rd     (node_rd_data),
        .i_verdict         (verdict),
        .i_report_seq      (report_seq),
        .i_report_locked   (report_locked),
        .o_node_rd_en      (node_rd_en),
        .o_node_wr_en      (node_wr_en),
        .o_node_addr       (node_addr),
        .o_node_wr_data    (node_wr_data),
        .o_wan_rd_en       (wan_rd_en),
        .o_wan_addr        (wan_addr),
        .o_access          (access),
        .o_msg_type        (msg_type),
        .o_sender_id       (sender_id)
    );

    // The captured sender number is also the value written back to the node table
    node_seq_check #(
        .SEQ_W (SEQ_W)
    ) u_node_check (
        .i_stored_seq (node_rd_data),
        .i_sender_seq (node_wr_data),
        .o_verdict    (verdict)
    );

    wan_owner_lock #(
        .NODE_ID_W (NODE_ID_W),
        .WAN_SEQ_W (WAN_SEQ_W)
    ) u_owner_lock (
        .i_access        (access),
        .i_msg_type      (msg_type),
        .i_sender_id     (sender_id),
        .i_owner_id      (owner_rd_data),
        .i_wan_seq       (wan_rd_data),
        .o_owner_wr_en   (owner_wr_en),
        .o_owner_wr_data (owner_wr_data),
        .o_wan_wr_en     (wan_wr_en),
        .o_wan_wr_data   (wan_wr_data),
        .o_report_seq    (report_seq),
        .o_report_locked (report_locked)
    );

    seq_table #(
        .entry_t (logic [SEQ_W-1:0]),
        .ADDR_W  (NODE_ID_W)
    ) u_node_table (
        .i_clk      (i_clk),
        .i_ap_rst_n (i_ap_rst_n),
        .i_rd_en    (node_rd_en),
        .i_wr_en    (node_wr_en),
        .i_addr     (node_addr),
        .i_wr_data  (node_wr_data),
        .o_rd_data  (node_rd_data)
    );

    seq_table #(
        .entry_t (logic [NODE_ID_W-1:0]),
        .ADDR_W  (WAN_DEST_W)
    ) u_owner_table (
        .i_clk      (i_clk),
        .i_ap_rst_n (i_ap_rst_n),
        .i_rd_en    (wan_rd_en),
        .i_wr_en    (owner_wr_en),
        .i_addr     (wan_addr),
        .i_wr_data  (owner_wr_data),
        .o_rd_data  (owner_rd_data)
    );

    seq_table #(
        .entry_t (logic [WAN_SEQ_W-1:0]),
        .ADDR_W  (WAN_DEST_W)
    ) u_wan_table (
        .i_clk      (i_clk),
        .i_ap_rst_n (i_ap_rst_n),
        .i_rd_en    (wan_rd_en),
        .i_wr_en    (wan_wr_en),
        .i_addr     (wan_addr),
        .i_wr_data  (wan_wr_data),
        .o_rd_data  (wan_rd_data)
    );

endmodule
